//--- filelist.f
verilog/i2c_pkg.sv
verilog/i2c_condition_timer.sv
verilog/i2c_sequencer.sv
verilog/i2c_line_ctrl.sv
verilog/i2c_master_fsm.sv
verif/i2c_fsm_assert.sv
verif/i2c_fsm_checker.sv
verif/tb_i2c_master_fsm.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the i2c master fsm testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_i2c_master_fsm \
    -o sim_i2c

./obj_dir/sim_i2c | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- verif/i2c_fsm_assert.sv
`timescale 1ns/1ps

module i2c_fsm_assert (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  i2c_pkg::fsm_state_e state_i,
    input  logic                rd_fifo_i,
    input  logic                wr_fifo_i
);

    // --------------------
    // fifo strobes
    // --------------------
    rd_single: assert property (@(posedge clk_i) disable iff (!rst_ni) rd_fifo_i |=> !rd_fifo_i)
        else $error("tx fifo read strobe longer than one cycle");

    wr_single: assert property (@(posedge clk_i) disable iff (!rst_ni) wr_fifo_i |=> !wr_fifo_i)
        else $error("rx fifo write strobe longer than one cycle");

    no_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni) !(rd_fifo_i && wr_fifo_i))
        else $error("both fifo strobes high together");

    // stop is the highest encoding
    legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                  4'(state_i) <= 4'(i2c_pkg::ST_STOP))
        else $error("sequencer state outside the enum");

endmodule

bind i2c_sequencer i2c_fsm_assert u_assert (
    .clk_i     (i2c_core_clock_i),
    .rst_ni    (reset_bit_i),
    .state_i   (state_o),
    .rd_fifo_i (read_fifo_en_o),
    .wr_fifo_i (write_fifo_en_o)
);

//--- verif/i2c_fsm_checker.sv
`timescale 1ns/1ps

module i2c_fsm_checker (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          enable_i,
    input  logic          rw_i,
    input  logic          sda_i,
    input  logic          tx_empty_i,
    input  logic          rx_full_i,
    input  i2c_pkg::cnt_t sdt_i,
    input  i2c_pkg::cnt_t presc_i,
    input  i2c_pkg::cnt_t edge_i,
    input  i2c_pkg::cnt_t bit_i,
    input  logic          start_i,
    input  logic          addr_i,
    input  logic          wdata_i,
    input  logic          rdata_i,
    input  logic          wack_i,
    input  logic          rack_i,
    input  logic          stop_i,
    input  logic          rd_fifo_i,
    input  logic          wr_fifo_i,
    input  logic          scl_en_i,
    input  logic          sda_en_i,
    output int            err_cnt_o
);

    i2c_pkg::fsm_state_e m_state;
    i2c_pkg::fsm_state_e m_next;
    i2c_pkg::cnt_t       m_count;
    i2c_pkg::cnt_t       twice;
    logic                m_pend;
    logic                pend_nx;
    logic                m_rd;
    logic                m_wr;
    logic                m_scl;
    logic                m_sda;
    logic                scl_nx;
    logic                sda_nx;
    logic                slot_done;
    logic                acked;
    int                  errs = 0;

    assign err_cnt_o = errs;
    assign twice     = presc_i + presc_i;
    assign slot_done = (bit_i == 8'd9) && (edge_i == presc_i);

    // --------------------
    // reference transitions
    // --------------------
    always_comb begin
        m_next  = m_state;
        pend_nx = m_pend;
        acked   = 1'b0;
        if (m_state == i2c_pkg::ST_IDLE && enable_i && m_count == 8'd0) begin
            m_next = i2c_pkg::ST_START;
        end else if (m_state == i2c_pkg::ST_START && m_count == 8'd1) begin
            m_next = i2c_pkg::ST_ADDR;
        end else if (m_state == i2c_pkg::ST_ADDR && bit_i == 8'd1) begin
            m_next = i2c_pkg::ST_ADDR_ACK;
        end else if (m_state == i2c_pkg::ST_WRITE_DATA && bit_i == 8'd1) begin
            m_next = i2c_pkg::ST_DATA_ACK;
        end else if (m_state == i2c_pkg::ST_READ_DATA && bit_i == 8'd1) begin
            m_next = i2c_pkg::ST_MASTER_ACK;
        end else if (m_state == i2c_pkg::ST_ADDR_ACK || m_state == i2c_pkg::ST_DATA_ACK) begin
            if (m_pend) begin
                if (slot_done) begin
                    m_next  = i2c_pkg::ST_STOP;
                    pend_nx = 1'b0;
                end
            end else if (bit_i == 8'd0) begin
                acked = !sda_i && (m_state == i2c_pkg::ST_ADDR_ACK || !tx_empty_i);
                if (!acked) pend_nx = 1'b1;
                else if (m_state == i2c_pkg::ST_ADDR_ACK && rw_i) m_next = i2c_pkg::ST_READ_DATA;
                else m_next = i2c_pkg::ST_WRITE_DATA;
            end
        end else if (m_state == i2c_pkg::ST_MASTER_ACK && slot_done) begin
            m_next = rx_full_i ? i2c_pkg::ST_STOP : i2c_pkg::ST_READ_DATA;
        end else if (m_state == i2c_pkg::ST_STOP && m_count == 8'd0) begin
            m_next = i2c_pkg::ST_IDLE;
        end
    end

    // expected line enables for the next clock
    always_comb begin
        scl_nx = m_scl;
        sda_nx = m_sda;
        case (m_state)
            i2c_pkg::ST_IDLE: begin
                scl_nx = 1'b0;
                sda_nx = 1'b0;
            end
            i2c_pkg::ST_START: begin
                scl_nx = 1'b0;
                sda_nx = !(edge_i > twice - 8'd3);
            end
            i2c_pkg::ST_ADDR: begin
                scl_nx = 1'b1;
                sda_nx = 1'b1;
            end
            i2c_pkg::ST_ADDR_ACK, i2c_pkg::ST_DATA_ACK: begin
                scl_nx = 1'b1;
                if (edge_i == presc_i - 8'd2) sda_nx = 1'b0;
            end
            i2c_pkg::ST_WRITE_DATA, i2c_pkg::ST_MASTER_ACK: begin
                scl_nx = 1'b1;
                if (edge_i == presc_i - 8'd3) sda_nx = 1'b1;
            end
            i2c_pkg::ST_READ_DATA: begin
                scl_nx = 1'b1;
                sda_nx = 1'b0;
            end
            default: begin
                if (edge_i == presc_i - 8'd3) sda_nx = 1'b1;   // stop
                if (edge_i == twice - 8'd2) scl_nx = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            m_state <= i2c_pkg::ST_IDLE;
            m_count <= sdt_i;
            m_pend  <= 1'b0;
            m_rd    <= 1'b0;
            m_wr    <= 1'b0;
            m_scl   <= 1'b0;
            m_sda   <= 1'b0;
        end else begin
            m_state <= m_next;
            m_pend  <= pend_nx;
            m_scl   <= scl_nx;
            m_sda   <= sda_nx;
            m_rd    <= (m_next == i2c_pkg::ST_WRITE_DATA) && (m_state == i2c_pkg::ST_ADDR_ACK
                       || m_state == i2c_pkg::ST_DATA_ACK);
            m_wr    <= (m_next == i2c_pkg::ST_MASTER_ACK) && (m_state == i2c_pkg::ST_READ_DATA);
            if (m_count != 8'd0 && ((m_state == i2c_pkg::ST_IDLE && enable_i)
                || ((m_state == i2c_pkg::ST_START || m_state == i2c_pkg::ST_STOP)
                    && edge_i >= presc_i))) begin
                m_count <= m_count - 8'd1;
            end else if (m_count == 8'd0 || (m_state == i2c_pkg::ST_ADDR && m_count == 8'd1)) begin
                m_count <= sdt_i;
            end
        end
    end

    // --------------------
    // comparison
    // --------------------
    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errs++;
            $display("[ERROR] %0t: %s is %b, model expects %b", $time, name, got, exp);
        end
    endtask

    always @(negedge clk_i) begin
        expect_bit("start_cnt_o", start_i, m_state == i2c_pkg::ST_START);
        expect_bit("write_addr_cnt_o", addr_i, m_state == i2c_pkg::ST_ADDR);
        expect_bit("write_data_cnt_o", wdata_i, m_state == i2c_pkg::ST_WRITE_DATA);
        expect_bit("read_data_cnt_o", rdata_i, m_state == i2c_pkg::ST_READ_DATA);
        expect_bit("write_ack_cnt_o", wack_i, m_state == i2c_pkg::ST_MASTER_ACK);
        expect_bit("read_ack_cnt_o", rack_i, m_state == i2c_pkg::ST_ADDR_ACK
                   || m_state == i2c_pkg::ST_DATA_ACK);
        expect_bit("stop_cnt_o", stop_i, m_state == i2c_pkg::ST_STOP);
        expect_bit("read_fifo_en_o", rd_fifo_i, m_rd);
        expect_bit("write_fifo_en_o", wr_fifo_i, m_wr);
        expect_bit("scl_en_o", scl_en_i, m_scl);
        expect_bit("sda_en_o", sda_en_i, m_sda);
    end

endmodule

//--- verif/tb_i2c_master_fsm.sv
`timescale 1ns/1ps

module tb_i2c_master_fsm;

    localparam int N_XFER    = 12;
    localparam int SIG_START = 0;
    localparam int SIG_STOP  = 1;

    logic          clk = 1'b0;
    logic          rst_n = 1'b0;
    logic          enable = 1'b0;
    logic          rw = 1'b0;
    logic          sda = 1'b0;
    logic          tx_empty = 1'b0;
    logic          rx_full = 1'b0;
    i2c_pkg::cnt_t sdt = 8'd4;
    i2c_pkg::cnt_t presc = 8'd4;
    i2c_pkg::cnt_t edge_cnt = 8'd0;
    i2c_pkg::cnt_t bit_cnt = 8'd9;
    logic          start_s, addr_s, wdata_s, rdata_s, wack_s, rack_s, stop_s;
    logic          rd_fifo, wr_fifo, scl_en, sda_en;
    logic          wrap;
    logic          data_seen = 1'b0;
    int unsigned   seed = 60667;
    int            n_bytes = 1;
    int            rd_seen = 0;
    int            wr_seen = 0;
    int            tb_errs = 0;
    int            cmp_errs;
    int            tests = 0;

    always #2 clk = ~clk;   // 4 ns period

    i2c_master_fsm dut (
        .i2c_core_clock_i (clk), .reset_bit_i (rst_n), .enable_bit_i (enable),
        .rw_bit_i (rw), .sda_i (sda), .trans_fifo_empty_i (tx_empty), .rev_fifo_full_i (rx_full),
        .state_done_time_i (sdt), .prescaler_i (presc), .counter_detect_edge_i (edge_cnt),
        .counter_data_ack_i (bit_cnt), .start_cnt_o (start_s), .write_addr_cnt_o (addr_s),
        .write_data_cnt_o (wdata_s), .read_data_cnt_o (rdata_s), .write_ack_cnt_o (wack_s),
        .read_ack_cnt_o (rack_s), .stop_cnt_o (stop_s), .read_fifo_en_o (rd_fifo),
        .write_fifo_en_o (wr_fifo), .scl_en_o (scl_en), .sda_en_o (sda_en)
    );

    i2c_fsm_checker u_check (
        .clk_i (clk), .rst_ni (rst_n), .enable_i (enable), .rw_i (rw), .sda_i (sda),
        .tx_empty_i (tx_empty), .rx_full_i (rx_full), .sdt_i (sdt), .presc_i (presc),
        .edge_i (edge_cnt), .bit_i (bit_cnt), .start_i (start_s), .addr_i (addr_s),
        .wdata_i (wdata_s), .rdata_i (rdata_s), .wack_i (wack_s), .rack_i (rack_s),
        .stop_i (stop_s), .rd_fifo_i (rd_fifo), .wr_fifo_i (wr_fifo), .scl_en_i (scl_en),
        .sda_en_i (sda_en), .err_cnt_o (cmp_errs)
    );

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    // --------------------
    // scl generator and fifo emulation
    // --------------------
    always @(negedge clk) begin
        if (rst_n) begin
            wrap     = (edge_cnt == presc + presc - 8'd1);
            edge_cnt = wrap ? 8'd0 : edge_cnt + 8'd1;
            if (!(addr_s || wdata_s || rdata_s || rack_s || wack_s)) bit_cnt = 8'd9;
            else if (wrap) bit_cnt = (bit_cnt == 8'd0) ? 8'd9 : bit_cnt - 8'd1;
            if (start_s) begin
                rd_seen   = 0;
                wr_seen   = 0;
                data_seen = 1'b0;
            end
            if (rd_fifo) rd_seen++;
            if (wr_fifo) wr_seen++;
            if (wdata_s || rdata_s) data_seen = 1'b1;
            tx_empty = (rd_seen >= n_bytes);
            rx_full  = (wr_seen >= n_bytes);
        end
    end

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic wait_level(input int sel, input logic level, input int limit,
                              input string what, output int cycles);
        cycles = 0;
        while (((sel == SIG_START) ? start_s : stop_s) !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) timeout_fail(what);
        end
    endtask

    task automatic run_transfer(input int idx);
        int unsigned r;
        int          cyc;
        logic        nack;
        logic        bad;
        r       = lcg_next();
        nack    = ((r % 5) == 2);
        n_bytes = 1 + int'((r >> 4) % 3);
        bad     = 1'b0;
        @(negedge clk);
        rw     = r[0];
        sda    = nack;
        enable = 1'b1;
        wait_level(SIG_START, 1'b1, 60, "start strobe", cyc);
        if (cyc != int'(sdt) + 1) begin
            $display("[ERROR] %0t: start after %0d clocks, expected %0d",
                     $time, cyc, int'(sdt) + 1);
            bad = 1'b1;
        end
        enable = 1'b0;
        cyc    = 0;
        while (!addr_s) begin
            if (scl_en) begin   // scl must stay off through start
                $display("[ERROR] %0t: scl_en_o high before the address phase", $time);
                bad = 1'b1;
            end
            @(negedge clk);
            cyc++;
            if (cyc > 200) timeout_fail("address phase");
        end
        wait_level(SIG_STOP, 1'b1, 4000, "stop strobe", cyc);
        sdt = i2c_pkg::cnt_t'(2 + lcg_next() % 8);   // reloads as the timer expires
        wait_level(SIG_STOP, 1'b0, 400, "return to idle", cyc);
        repeat (3) @(negedge clk);
        if (nack ? (data_seen || rd_seen != 0 || wr_seen != 0)
                 : (rw ? (wr_seen != n_bytes || rd_seen != 0)
                       : (rd_seen != n_bytes || wr_seen != 0))) begin
            $display("[ERROR] %0t: fifo strobes rd %0d wr %0d for %0d byte(s)",
                     $time, rd_seen, wr_seen, n_bytes);
            bad = 1'b1;
        end
        $display("test %0d: %s, %0d byte(s): %s", idx,
                 nack ? "address nack" : (rw ? "read" : "write"), n_bytes, bad ? "FAILED" : "ok");
        tests++;
        if (bad) tb_errs++;
    endtask

    initial begin
        logic bad;
        bad = 1'b0;
        sdt = i2c_pkg::cnt_t'(2 + lcg_next() % 8);
        repeat (10) begin
            @(negedge clk);
            if ({start_s, addr_s, wdata_s, rdata_s, wack_s, rack_s, stop_s,
                 rd_fifo, wr_fifo, scl_en, sda_en} != 11'd0) begin
                $display("[ERROR] %0t: strobe or enable high during reset", $time);
                bad = 1'b1;
            end
        end
        rst_n = 1'b1;
        @(negedge clk);
        if ({start_s, addr_s, wdata_s, rdata_s, wack_s, rack_s, stop_s,
             rd_fifo, wr_fifo, scl_en, sda_en} != 11'd0) begin
            $display("[ERROR] %0t: strobe or enable high right after reset", $time);
            bad = 1'b1;
        end
        $display("test 0: reset values: %s", bad ? "FAILED" : "ok");
        tests++;
        if (bad) tb_errs++;
        for (int i = 1; i <= N_XFER; i++) begin
            run_transfer(i);
        end
        $display("tests: %0d, failed tests: %0d, compare errors: %0d", tests, tb_errs, cmp_errs);
        if (tb_errs == 0 && cmp_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/i2c_condition_timer.sv
`timescale 1ns/1ps

module i2c_condition_timer (
    input  logic                i2c_core_clock_i,
    input  logic                reset_bit_i,
    input  logic                enable_bit_i,
    input  i2c_pkg::fsm_state_e state_i,
    input  i2c_pkg::cnt_t       state_done_time_i,
    input  i2c_pkg::cnt_t       prescaler_i,
    input  i2c_pkg::cnt_t       counter_detect_edge_i,
    output logic                cond_zero_o,
    output logic                cond_last_o
);

    i2c_pkg::cnt_t count_q;
    logic          idle_run;     // idle wait before start
    logic          cond_run;     // start or stop hold time
    logic          edge_late;    // second half of the scl period

    assign edge_late = (counter_detect_edge_i >= prescaler_i);

    assign idle_run = (state_i == i2c_pkg::ST_IDLE) && enable_bit_i;

    assign cond_run = ((state_i == i2c_pkg::ST_START) || (state_i == i2c_pkg::ST_STOP))
                      && edge_late;

    // --------------------
    // shared down-counter
    // --------------------
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i) begin
            count_q <= state_done_time_i;
        end else if ((idle_run || cond_run) && !cond_zero_o) begin
            count_q <= count_q - i2c_pkg::cnt_t'(1);
        end else if (cond_zero_o) begin
            count_q <= state_done_time_i;                 // reload once expired
        end else if ((state_i == i2c_pkg::ST_ADDR) && cond_last_o) begin
            count_q <= state_done_time_i;                 // start left one tick early
        end
    end

    assign cond_zero_o = (count_q == i2c_pkg::cnt_t'(0));
    assign cond_last_o = (count_q == i2c_pkg::cnt_t'(1));

endmodule

//--- verilog/i2c_line_ctrl.sv
`timescale 1ns/1ps

module i2c_line_ctrl (
    input  logic                i2c_core_clock_i,
    input  logic                reset_bit_i,
    input  i2c_pkg::fsm_state_e state_i,
    input  i2c_pkg::cnt_t       prescaler_i,
    input  i2c_pkg::cnt_t       counter_detect_edge_i,
    output logic                start_cnt_o,
    output logic                write_addr_cnt_o,
    output logic                write_data_cnt_o,
    output logic                read_data_cnt_o,
    output logic                write_ack_cnt_o,
    output logic                read_ack_cnt_o,
    output logic                stop_cnt_o,
    output logic                sda_en_o,
    output logic                scl_en_o
);

    i2c_pkg::cnt_t twice_presc;
    logic          sda_d;
    logic          scl_d;
    logic          at_release;   // sda handed to the slave
    logic          at_drive;     // sda taken back by the master
    logic          start_hold;   // sda still driven low in start
    logic          scl_off;      // scl let go for the stop condition

    assign twice_presc = prescaler_i + prescaler_i;
    assign at_release  = (counter_detect_edge_i == (prescaler_i - i2c_pkg::SDA_RELEASE_OFS));
    assign at_drive    = (counter_detect_edge_i == (prescaler_i - i2c_pkg::SDA_DRIVE_OFS));
    assign start_hold  = (counter_detect_edge_i <= (twice_presc - i2c_pkg::START_SDA_OFS));
    assign scl_off     = (counter_detect_edge_i == (twice_presc - i2c_pkg::cnt_t'(2)));

    // --------------------
    // phase strobes
    // --------------------
    assign start_cnt_o      = (state_i == i2c_pkg::ST_START);
    assign write_addr_cnt_o = (state_i == i2c_pkg::ST_ADDR);
    assign write_data_cnt_o = (state_i == i2c_pkg::ST_WRITE_DATA);
    assign read_data_cnt_o  = (state_i == i2c_pkg::ST_READ_DATA);
    assign write_ack_cnt_o  = (state_i == i2c_pkg::ST_MASTER_ACK);
    assign read_ack_cnt_o   = (state_i == i2c_pkg::ST_ADDR_ACK)
                              || (state_i == i2c_pkg::ST_DATA_ACK);   // both slave acks
    assign stop_cnt_o       = (state_i == i2c_pkg::ST_STOP);

    // --------------------
    // drive enables
    // --------------------
    always_comb begin
        sda_d = sda_en_o;
        scl_d = scl_en_o;
        case (state_i)
            i2c_pkg::ST_IDLE: begin
                sda_d = 1'b0;
                scl_d = 1'b0;
            end
            i2c_pkg::ST_START: begin
                sda_d = start_hold;
                scl_d = 1'b0;
            end
            i2c_pkg::ST_ADDR: begin
                sda_d = 1'b1;
                scl_d = 1'b1;
            end
            i2c_pkg::ST_ADDR_ACK, i2c_pkg::ST_DATA_ACK: begin
                if (at_release) sda_d = 1'b0;   // let the slave answer
                scl_d = 1'b1;
            end
            i2c_pkg::ST_WRITE_DATA, i2c_pkg::ST_MASTER_ACK: begin
                if (at_drive) sda_d = 1'b1;
                scl_d = 1'b1;
            end
            i2c_pkg::ST_READ_DATA: begin
                sda_d = 1'b0;                   // slave owns sda
                scl_d = 1'b1;
            end
            i2c_pkg::ST_STOP: begin
                if (at_drive) sda_d = 1'b1;
                if (scl_off) scl_d = 1'b0;
            end
            default: begin
                sda_d = 1'b0;
                scl_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i) begin
            sda_en_o <= 1'b0;
            scl_en_o <= 1'b0;
        end else begin
            sda_en_o <= sda_d;
            scl_en_o <= scl_d;
        end
    end

endmodule

//--- verilog/i2c_master_fsm.sv
`timescale 1ns/1ps

module i2c_master_fsm (
    input  logic          i2c_core_clock_i,
    input  logic          reset_bit_i,
    input  logic          enable_bit_i,
    input  logic          rw_bit_i,
    input  logic          sda_i,
    input  logic          trans_fifo_empty_i,
    input  logic          rev_fifo_full_i,
    input  i2c_pkg::cnt_t state_done_time_i,
    input  i2c_pkg::cnt_t prescaler_i,
    input  i2c_pkg::cnt_t counter_detect_edge_i,
    input  i2c_pkg::cnt_t counter_data_ack_i,
    output logic          start_cnt_o,
    output logic          write_addr_cnt_o,
    output logic          write_data_cnt_o,
    output logic          read_data_cnt_o,
    output logic          write_ack_cnt_o,
    output logic          read_ack_cnt_o,
    output logic          stop_cnt_o,
    output logic          read_fifo_en_o,
    output logic          write_fifo_en_o,
    output logic          scl_en_o,
    output logic          sda_en_o
);

    i2c_pkg::fsm_state_e state;
    logic                cond_zero;   // condition time expired
    logic                cond_last;   // one tick left

    i2c_condition_timer u_timer (
        .i2c_core_clock_i      (i2c_core_clock_i),
        .reset_bit_i           (reset_bit_i),
        .enable_bit_i          (enable_bit_i),
        .state_i               (state),
        .state_done_time_i     (state_done_time_i),
        .prescaler_i           (prescaler_i),
        .counter_detect_edge_i (counter_detect_edge_i),
        .cond_zero_o           (cond_zero),
        .cond_last_o           (cond_last)
    );

    i2c_sequencer u_seq (
        .i2c_core_clock_i      (i2c_core_clock_i),
        .reset_bit_i           (reset_bit_i),
        .enable_bit_i          (enable_bit_i),
        .rw_bit_i              (rw_bit_i),
        .sda_i                 (sda_i),
        .trans_fifo_empty_i    (trans_fifo_empty_i),
        .rev_fifo_full_i       (rev_fifo_full_i),
        .cond_zero_i           (cond_zero),
        .cond_last_i           (cond_last),
        .prescaler_i           (prescaler_i),
        .counter_detect_edge_i (counter_detect_edge_i),
        .counter_data_ack_i    (counter_data_ack_i),
        .state_o               (state),
        .read_fifo_en_o        (read_fifo_en_o),
        .write_fifo_en_o       (write_fifo_en_o)
    );

    i2c_line_ctrl u_line (
        .i2c_core_clock_i      (i2c_core_clock_i),
        .reset_bit_i           (reset_bit_i),
        .state_i               (state),
        .prescaler_i           (prescaler_i),
        .counter_detect_edge_i (counter_detect_edge_i),
        .start_cnt_o           (start_cnt_o),
        .write_addr_cnt_o      (write_addr_cnt_o),
        .write_data_cnt_o      (write_data_cnt_o),
        .read_data_cnt_o       (read_data_cnt_o),
        .write_ack_cnt_o       (write_ack_cnt_o),
        .read_ack_cnt_o        (read_ack_cnt_o),
        .stop_cnt_o            (stop_cnt_o),
        .sda_en_o              (sda_en_o),
        .scl_en_o              (scl_en_o)
    );

endmodule

//--- verilog/i2c_pkg.sv
package i2c_pkg;

    // --------------------
    // bus phases
    // --------------------
    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,   // bus free, waiting for enable
        ST_START      = 4'd1,
        ST_ADDR       = 4'd2,   // 7-bit address plus rw bit
        ST_ADDR_ACK   = 4'd3,   // slave acks the address
        ST_WRITE_DATA = 4'd4,
        ST_DATA_ACK   = 4'd5,   // slave acks a written byte
        ST_READ_DATA  = 4'd6,
        ST_MASTER_ACK = 4'd7,   // master acks a read byte
        ST_STOP       = 4'd8
    } fsm_state_e;

    // --------------------
    // counters
    // --------------------
    localparam int CNT_W = 8;

    typedef logic [CNT_W-1:0] cnt_t;

    // bit counter values as counted down by the datapath
    localparam cnt_t BIT_LAST = cnt_t'(1);   // last bit of an addr or data phase
    localparam cnt_t BIT_ACK  = cnt_t'(0);   // ack bit on the line
    localparam cnt_t BIT_WRAP = cnt_t'(9);   // counter reloaded and ack slot over

    // --------------------
    // sda timing offsets
    // --------------------
    // measured against the edge counter of the clock generator
    localparam cnt_t SDA_RELEASE_OFS = cnt_t'(2);   // below prescaler
    localparam cnt_t SDA_DRIVE_OFS   = cnt_t'(3);   // below prescaler
    localparam cnt_t START_SDA_OFS   = cnt_t'(3);   // below twice the prescaler

endpackage

//--- verilog/i2c_sequencer.sv
`timescale 1ns/1ps

module i2c_sequencer (
    input  logic                i2c_core_clock_i,
    input  logic                reset_bit_i,
    input  logic                enable_bit_i,
    input  logic                rw_bit_i,
    input  logic                sda_i,
    input  logic                trans_fifo_empty_i,
    input  logic                rev_fifo_full_i,
    input  logic                cond_zero_i,
    input  logic                cond_last_i,
    input  i2c_pkg::cnt_t       prescaler_i,
    input  i2c_pkg::cnt_t       counter_detect_edge_i,
    input  i2c_pkg::cnt_t       counter_data_ack_i,
    output i2c_pkg::fsm_state_e state_o,
    output logic                read_fifo_en_o,
    output logic                write_fifo_en_o
);

    i2c_pkg::fsm_state_e state_q;
    i2c_pkg::fsm_state_e state_d;
    logic                stop_pend_q;   // stop decided, waiting for the slot to end
    logic                stop_set;
    logic                stop_take;
    logic                bit_last;
    logic                bit_ack;
    logic                slot_end;

    assign bit_last = (counter_data_ack_i == i2c_pkg::BIT_LAST);
    assign bit_ack  = (counter_data_ack_i == i2c_pkg::BIT_ACK);

    // ack slot closes when the bit counter has wrapped and scl is mid period
    assign slot_end = (counter_data_ack_i == i2c_pkg::BIT_WRAP)
                      && (counter_detect_edge_i == prescaler_i);

    // --------------------
    // next-state rules
    // --------------------
    always_comb begin
        state_d   = state_q;
        stop_set  = 1'b0;
        stop_take = 1'b0;
        case (state_q)
            i2c_pkg::ST_IDLE: begin
                if (enable_bit_i && cond_zero_i) begin
                    state_d = i2c_pkg::ST_START;
                end
            end
            i2c_pkg::ST_START: begin
                if (cond_last_i) begin
                    state_d = i2c_pkg::ST_ADDR;
                end
            end
            i2c_pkg::ST_ADDR: begin
                if (bit_last) begin
                    state_d = i2c_pkg::ST_ADDR_ACK;
                end
            end
            i2c_pkg::ST_ADDR_ACK: begin
                if (stop_pend_q) begin
                    if (slot_end) begin
                        state_d   = i2c_pkg::ST_STOP;
                        stop_take = 1'b1;
                    end
                end else if (bit_ack) begin
                    if (sda_i) begin
                        stop_set = 1'b1;                     // address nack
                    end else if (rw_bit_i) begin
                        state_d = i2c_pkg::ST_READ_DATA;
                    end else begin
                        state_d = i2c_pkg::ST_WRITE_DATA;
                    end
                end
            end
            i2c_pkg::ST_WRITE_DATA: begin
                if (bit_last) begin
                    state_d = i2c_pkg::ST_DATA_ACK;
                end
            end
            i2c_pkg::ST_DATA_ACK: begin
                if (stop_pend_q) begin
                    if (slot_end) begin
                        state_d   = i2c_pkg::ST_STOP;
                        stop_take = 1'b1;
                    end
                end else if (bit_ack) begin
                    if (sda_i || trans_fifo_empty_i) begin
                        stop_set = 1'b1;                     // nack or nothing to send
                    end else begin
                        state_d = i2c_pkg::ST_WRITE_DATA;
                    end
                end
            end
            i2c_pkg::ST_READ_DATA: begin
                if (bit_last) begin
                    state_d = i2c_pkg::ST_MASTER_ACK;
                end
            end
            i2c_pkg::ST_MASTER_ACK: begin
                if (slot_end) begin
                    if (rev_fifo_full_i) begin
                        state_d = i2c_pkg::ST_STOP;
                    end else begin
                        state_d = i2c_pkg::ST_READ_DATA;
                    end
                end
            end
            i2c_pkg::ST_STOP: begin
                if (cond_zero_i) begin
                    state_d = i2c_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = i2c_pkg::ST_IDLE;
            end
        endcase
    end

    // --------------------
    // state and fifo pulses
    // --------------------
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i) begin
            state_q         <= i2c_pkg::ST_IDLE;
            read_fifo_en_o  <= 1'b0;
            write_fifo_en_o <= 1'b0;
        end else begin
            state_q         <= state_d;
            // fetch the next tx byte as a write phase begins
            read_fifo_en_o  <= (state_d == i2c_pkg::ST_WRITE_DATA)
                               && ((state_q == i2c_pkg::ST_ADDR_ACK)
                                   || (state_q == i2c_pkg::ST_DATA_ACK));
            write_fifo_en_o <= (state_d == i2c_pkg::ST_MASTER_ACK)
                               && (state_q == i2c_pkg::ST_READ_DATA);   // byte complete
        end
    end

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i) begin
            stop_pend_q <= 1'b0;
        end else if (stop_take) begin
            stop_pend_q <= 1'b0;
        end else if (stop_set) begin
            stop_pend_q <= 1'b1;
        end
    end

    assign state_o = state_q;

endmodule
